// File: verilog/bram_geom_pkg.sv
// Parameter RAM geometry
package bram_geom_pkg;

  // Port widths
  localparam int W_WIDTH = 8;                      // Producer side byte
  localparam int R_WIDTH = 32;                     // Consumer side word

  // Depths
  localparam int W_DEPTH = 64;
  localparam int R_DEPTH = W_DEPTH * W_WIDTH / R_WIDTH; // 16 wide words
  localparam int RATIO   = R_WIDTH / W_WIDTH;           // Bytes per wide word

  // Address widths
  localparam int W_ADDR_WIDTH = $clog2(W_DEPTH);
  localparam int R_ADDR_WIDTH = $clog2(R_DEPTH);

  // Read pipeline depth of the RAM
  localparam int LATENCY = 3;

  // Data words
  typedef logic [W_WIDTH-1:0] w_data_t;
  typedef logic [R_WIDTH-1:0] r_data_t;

  // Addresses
  typedef logic [W_ADDR_WIDTH-1:0] w_addr_t;
  typedef logic [R_ADDR_WIDTH-1:0] r_addr_t;

  // Word k of the read side holds bytes RATIO*k up to RATIO*k+RATIO-1,
  // lowest address in the lowest byte lane

endpackage

// File: verilog/cyc_buf_pkg.sv
// Cyclic buffer definitions
package cyc_buf_pkg;

  // Ring buffer covers every read in flight plus the one on the output
  localparam int BUFFER_DEPTH = bram_geom_pkg::LATENCY + 1;
  localparam int PTR_WIDTH    = $clog2(BUFFER_DEPTH);

  // Controller phases
  typedef enum logic [1:0] {
    WRITE_S  = 2'd0, // Table is being loaded
    FILL_1_S = 2'd1, // Reads issued, nothing returned yet
    FILL_2_S = 2'd2, // Output valid, buffer still priming
    READ_S   = 2'd3  // Steady replay
  } cyc_state_t;

  // RAM write port, byte travels beside it
  typedef struct packed {
    logic                   en;
    bram_geom_pkg::w_addr_t addr;
  } bram_wr_t;

  // RAM read port
  typedef struct packed {
    logic                   en;
    bram_geom_pkg::r_addr_t addr;
  } bram_rd_t;

  // Write struct is 1 + W_ADDR_WIDTH bits (7)
  // Read struct is 1 + R_ADDR_WIDTH bits (5)

  // Pointers wrap at BUFFER_DEPTH-1
  // m_data is muxed from the entry under the read pointer

endpackage

// File: verilog/n_delay.sv
// Clock-enabled delay line
`timescale 1ns/1ps

module n_delay #(
  parameter int N     = 3,
  parameter int WIDTH = 1
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             clken,
  input  logic [WIDTH-1:0] data_in,
  output logic [WIDTH-1:0] data_out
);

  logic [WIDTH-1:0] taps [N]; // taps[0] is the first stage

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < N; i++) begin
        taps[i] <= '0;
      end
    end else if (clken) begin
      taps[0] <= data_in;
      for (int i = 1; i < N; i++) begin
        taps[i] <= taps[i-1]; // Shift one stage
      end
    end
  end

  // Last stage is the delayed copy
  assign data_out = taps[N-1];

endmodule

// File: verilog/sdp_bram.sv
// Asymmetric dual port RAM
`timescale 1ns/1ps

module sdp_bram (
  input  logic                   clk,
  input  logic                   clken,
  input  cyc_buf_pkg::bram_wr_t  wr,
  input  bram_geom_pkg::w_data_t wr_data,
  input  cyc_buf_pkg::bram_rd_t  rd,
  output bram_geom_pkg::r_data_t r_data
);

  localparam int LAT = bram_geom_pkg::LATENCY;

  // Byte wide storage
  bram_geom_pkg::w_data_t mem [bram_geom_pkg::W_DEPTH];

  // Read word assembled from RATIO neighbouring bytes
  bram_geom_pkg::r_data_t rd_word;

  // Output pipeline, stage LAT-1 drives the port
  bram_geom_pkg::r_data_t rd_pipe [LAT];

  // Narrow write port
  always_ff @(posedge clk) begin
    if (clken && wr.en) begin
      mem[wr.addr] <= wr_data;
    end
  end

  // Lowest byte address lands in the lowest lane
  always_comb begin
    bram_geom_pkg::w_addr_t byte_addr;
    rd_word = '0;
    for (int i = 0; i < bram_geom_pkg::RATIO; i++) begin
      byte_addr = bram_geom_pkg::w_addr_t'(rd.addr * bram_geom_pkg::RATIO + i);
      rd_word[i*bram_geom_pkg::W_WIDTH +: bram_geom_pkg::W_WIDTH] = mem[byte_addr];
    end
  end

  // Wide read pipeline
  always_ff @(posedge clk) begin
    if (clken) begin
      if (rd.en) begin
        rd_pipe[0] <= rd_word; // Array sample
      end
      for (int s = 1; s < LAT; s++) begin
        rd_pipe[s] <= rd_pipe[s-1];
      end
    end
  end

  // Data shows up LAT enabled cycles after the read
  assign r_data = rd_pipe[LAT-1];

endmodule

// File: verilog/always_valid_cyclic_bram.sv
// Always-valid cyclic RAM wrapper
`timescale 1ns/1ps

module always_valid_cyclic_bram (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   clken,
  input  logic                   s_valid_ready,
  input  bram_geom_pkg::w_data_t s_data,
  input  bram_geom_pkg::w_addr_t w_addr_max_1,
  input  bram_geom_pkg::r_addr_t r_addr_max_1,
  output bram_geom_pkg::r_data_t m_data,
  output logic                   m_valid,
  input  logic                   m_ready
);

  localparam int PW = cyc_buf_pkg::PTR_WIDTH;
  localparam logic [PW-1:0] LAST_PTR = PW'(cyc_buf_pkg::BUFFER_DEPTH - 1);

  cyc_buf_pkg::cyc_state_t state, state_next;

  logic m_valid_ready;
  logic bram_r_en;
  logic bram_valid_out;
  logic wr_en;

  bram_geom_pkg::w_addr_t addr_w_prev, addr_w;
  bram_geom_pkg::r_addr_t addr_r, addr_r_next;
  bram_geom_pkg::r_data_t bram_r_data;

  cyc_buf_pkg::bram_wr_t bram_wr;
  cyc_buf_pkg::bram_rd_t bram_rd;

  logic [PW-1:0] w_ptr, w_ptr_next;
  logic [PW-1:0] r_ptr, r_ptr_next;

  // Ring buffer in front of the consumer
  bram_geom_pkg::r_data_t ring_q [cyc_buf_pkg::BUFFER_DEPTH];

  assign m_valid_ready = m_valid && m_ready;

  // Table is frozen once the write phase is over
  assign wr_en = s_valid_ready && (state == cyc_buf_pkg::WRITE_S);

  always_comb begin
    state_next = state;
    case (state)
      cyc_buf_pkg::WRITE_S:
        if (wr_en && addr_w == w_addr_max_1) state_next = cyc_buf_pkg::FILL_1_S;
      cyc_buf_pkg::FILL_1_S:
        if (bram_valid_out) state_next = cyc_buf_pkg::FILL_2_S; // First word back
      cyc_buf_pkg::FILL_2_S:
        if (bram_valid_out && w_ptr == LAST_PTR) state_next = cyc_buf_pkg::READ_S;
      default:
        state_next = state; // Replay until reset
    endcase
  end

  // FILL_1_S issues exactly LATENCY+1 reads before the first word returns,
  // after that a read is issued only when a word leaves the buffer
  always_comb begin
    bram_r_en = 1'b0;
    m_valid   = 1'b0;
    case (state)
      cyc_buf_pkg::FILL_1_S: begin
        bram_r_en = 1'b1;
      end
      cyc_buf_pkg::FILL_2_S, cyc_buf_pkg::READ_S: begin
        bram_r_en = m_ready; // One slot freed per transfer
        m_valid   = 1'b1;
      end
      default: begin
        bram_r_en = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= cyc_buf_pkg::WRITE_S;
    end else if (clken) begin
      state <= state_next;
    end
  end

  // Write address, starts at all ones so the first byte goes to 0
  assign addr_w = (addr_w_prev == w_addr_max_1) ? '0 : addr_w_prev + 1'b1;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      addr_w_prev <= '1;
    end else if (clken && wr_en) begin
      addr_w_prev <= addr_w;
    end
  end

  // Read address wraps at the table end
  assign addr_r_next = (addr_r == r_addr_max_1) ? '0 : addr_r + 1'b1;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      addr_r <= '0;
    end else if (clken && bram_r_en) begin
      addr_r <= addr_r_next;
    end
  end

  assign bram_wr = '{en: wr_en, addr: addr_w};
  assign bram_rd = '{en: bram_r_en, addr: addr_r};

  sdp_bram u_bram (
    .clk     (clk),
    .clken   (clken),
    .wr      (bram_wr),
    .wr_data (s_data),
    .rd      (bram_rd),
    .r_data  (bram_r_data)
  );

  // Marks cycles where bram_r_data is a fresh word
  n_delay #(
    .N     (bram_geom_pkg::LATENCY),
    .WIDTH (1)
  ) u_valid_delay (
    .clk      (clk),
    .rst_n    (rst_n),
    .clken    (clken),
    .data_in  (bram_r_en),
    .data_out (bram_valid_out)
  );

  assign w_ptr_next = (w_ptr == LAST_PTR) ? '0 : w_ptr + 1'b1;
  assign r_ptr_next = (r_ptr == LAST_PTR) ? '0 : r_ptr + 1'b1;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      w_ptr <= '0;
      r_ptr <= '0;
    end else if (clken) begin
      if (bram_valid_out) w_ptr <= w_ptr_next;
      if (m_valid_ready)  r_ptr <= r_ptr_next;
    end
  end

  always_ff @(posedge clk) begin
    if (clken && bram_valid_out) begin
      ring_q[w_ptr] <= bram_r_data;
    end
  end

  // Unregistered output mux
  assign m_data = ring_q[r_ptr];

endmodule

// File: verilog/lrelu_param_store.sv
// Activation parameter store
`timescale 1ns/1ps

module lrelu_param_store (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   clken,
  input  logic                   s_valid_ready,
  input  bram_geom_pkg::w_data_t s_data,
  input  bram_geom_pkg::w_addr_t w_addr_max_1, // Held from reset onward
  input  bram_geom_pkg::r_addr_t r_addr_max_1, // Held from reset onward
  output bram_geom_pkg::r_data_t m_data,
  output logic                   m_valid,
  input  logic                   m_ready
);

  // Byte stream in, wide words replayed forever out
  always_valid_cyclic_bram u_cyc_bram (
    .clk           (clk),
    .rst_n         (rst_n),
    .clken         (clken),
    .s_valid_ready (s_valid_ready),
    .s_data        (s_data),
    .w_addr_max_1  (w_addr_max_1),
    .r_addr_max_1  (r_addr_max_1),
    .m_data        (m_data),
    .m_valid       (m_valid),
    .m_ready       (m_ready)
  );

endmodule

// File: verif/tb_clk_rst.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clk_rst #(
  parameter int PERIOD_NS  = 8,
  parameter int RST_CYCLES = 16
) (
  output logic clk,
  output logic rst_n,
  input  logic rst_req
);

  initial clk = 1'b0;
  always #(PERIOD_NS / 2) clk = ~clk;

  // Power-on reset, then a fresh one on every request edge
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    forever begin
      @(posedge rst_req);
      rst_n <= 1'b0;
      repeat (RST_CYCLES) @(posedge clk); // Same length as at start
      rst_n <= 1'b1;
    end
  end

endmodule

// File: verif/tb_lrelu_param_store.sv
// Parameter store testbench
`timescale 1ns/1ps

module tb_lrelu_param_store;

  localparam string TESTDATA = "verif/cyclic_bram_testdata.txt";
  localparam int    CLK_NS   = 8;

  // One line of the test table
  typedef struct packed {
    bram_geom_pkg::w_addr_t w_max;
    bram_geom_pkg::r_addr_t r_max;
    logic [15:0]            n_reads;
    logic [7:0]             sv_pct;  // s_valid_ready duty
    logic [7:0]             mr_pct;  // m_ready duty
    logic [7:0]             ck_pct;  // clken duty
    bram_geom_pkg::w_data_t base;
    bram_geom_pkg::r_data_t first_word;
    bram_geom_pkg::r_data_t last_word;
  } test_vec_t;

  logic                   clk;
  logic                   rst_n;
  logic                   rst_req;
  logic                   clken;
  logic                   s_valid_ready;
  bram_geom_pkg::w_data_t s_data;
  bram_geom_pkg::w_addr_t w_addr_max_1;
  bram_geom_pkg::r_addr_t r_addr_max_1;
  bram_geom_pkg::r_data_t m_data;
  logic                   m_valid;
  logic                   m_ready;

  test_vec_t   tests[$];
  logic [31:0] rng_state    = 32'h6cdd;
  longint      budget_ns    = 0;
  int          total_errs   = 0;
  int          failed_tests = 0;
  logic        load_ok;

  tb_clk_rst #(.PERIOD_NS(CLK_NS), .RST_CYCLES(16)) u_clk_rst (
    .clk     (clk),
    .rst_n   (rst_n),
    .rst_req (rst_req)
  );

  lrelu_param_store dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .clken         (clken),
    .s_valid_ready (s_valid_ready),
    .s_data        (s_data),
    .w_addr_max_1  (w_addr_max_1),
    .r_addr_max_1  (r_addr_max_1),
    .m_data        (m_data),
    .m_valid       (m_valid),
    .m_ready       (m_ready)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // True with the given chance in percent
  function automatic logic draw_percent(input int pct);
    rng_state = lcg_step(rng_state);
    return (int'(rng_state[31:16]) % 100) < pct;
  endfunction

  // Byte stored at write address a
  function automatic bram_geom_pkg::w_data_t table_byte(input bram_geom_pkg::w_data_t base,
                                                        input int a);
    return bram_geom_pkg::w_data_t'(int'(base) + 3 * a);
  endfunction

  // Wide word k with the lowest byte address in the lowest lane
  function automatic bram_geom_pkg::r_data_t packed_word(input bram_geom_pkg::w_data_t base,
                                                         input int k);
    bram_geom_pkg::r_data_t w;
    w = '0;
    for (int j = 0; j < bram_geom_pkg::RATIO; j++) begin
      w[j*8 +: 8] = table_byte(base, k * bram_geom_pkg::RATIO + j);
    end
    return w;
  endfunction

  task automatic load_tests();
    int          fd;
    int          cnt;
    int          wm, rm, nr, svp, mrp, ckp;
    logic [31:0] base, fw, lw;
    string       line;
    test_vec_t   tv;
    load_ok = 1'b1;
    fd = $fopen(TESTDATA, "r");
    if (fd == 0) begin
      $display("Cannot open the test data file %s", TESTDATA);
      load_ok = 1'b0;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        cnt = $fgets(line, fd);
        if (cnt > 0 && line.getc(0) != 8'h23) begin // Lines with # are notes
          cnt = $sscanf(line, "%d %d %d %d %d %d %h %h %h",
                        wm, rm, nr, svp, mrp, ckp, base, fw, lw);
          if (cnt == 9 && (wm + 1) == bram_geom_pkg::RATIO * (rm + 1)) begin
            tv.w_max      = bram_geom_pkg::w_addr_t'(wm);
            tv.r_max      = bram_geom_pkg::r_addr_t'(rm);
            tv.n_reads    = 16'(nr);
            tv.sv_pct     = 8'(svp);
            tv.mr_pct     = 8'(mrp);
            tv.ck_pct     = 8'(ckp);
            tv.base       = bram_geom_pkg::w_data_t'(base);
            tv.first_word = fw;
            tv.last_word  = lw;
            tests.push_back(tv);
          end else if (cnt > 0) begin
            $display("Test data line is malformed or breaks the limit rule: %s", line);
            load_ok = 1'b0;
          end
        end
      end
      $fclose(fd);
      if (tests.size() == 0) begin
        $display("The test data file holds no tests");
        load_ok = 1'b0;
      end
    end
  endtask

  task automatic apply_reset(input test_vec_t tv);
    @(posedge clk);
    rst_req       <= 1'b1;
    clken         <= 1'b1;
    s_valid_ready <= 1'b0;
    s_data        <= '0;
    m_ready       <= 1'b0;
    w_addr_max_1  <= tv.w_max; // Limits settle during reset
    r_addr_max_1  <= tv.r_max;
    @(posedge clk);
    rst_req <= 1'b0;
    @(posedge rst_n);
  endtask

  task automatic run_test(input int t);
    test_vec_t              tv;
    int                     n_wr;
    int                     n_rd;
    int                     errs;
    logic                   seen_valid;
    logic                   hold_due;
    logic                   strobe;
    bram_geom_pkg::r_data_t held_data, exp_word, first_seen, last_seen;
    tv         = tests[t];
    n_wr       = 0;
    n_rd       = 0;
    errs       = 0;
    seen_valid = 1'b0;
    hold_due   = 1'b0;
    held_data  = '0;
    first_seen = '0;
    last_seen  = '0;
    apply_reset(tv);
    while (n_rd < int'(tv.n_reads)) begin
      @(posedge clk);
      // Samples here are the values from before this edge
      if (hold_due) begin
        assert (m_data === held_data) else begin
          $display("m_data changed without a transfer in test %0d", t + 1);
          errs++;
        end
      end
      if (seen_valid) begin
        assert (m_valid === 1'b1) else begin
          $display("m_valid fell after it had risen in test %0d", t + 1);
          errs++;
        end
      end
      if (n_wr <= int'(tv.w_max)) begin
        assert (m_valid === 1'b0) else begin
          $display("m_valid rose before the table was loaded in test %0d", t + 1);
          errs++;
        end
      end
      hold_due  = m_valid && !(clken && m_ready);
      held_data = m_data;
      if (m_valid === 1'b1) seen_valid = 1'b1;
      if (clken) begin
        if (s_valid_ready && n_wr <= int'(tv.w_max)) n_wr++;
        if (m_valid && m_ready) begin
          exp_word = packed_word(tv.base, n_rd % (int'(tv.r_max) + 1));
          assert (m_data === exp_word) else begin
            $display("mismatch m_data: expected 0x%08h, got 0x%08h (test %0d, read %0d)",
                     exp_word, m_data, t + 1, n_rd);
            errs++;
          end
          if (n_rd == 0) first_seen = m_data;
          last_seen = m_data;
          n_rd++;
        end
      end
      // Next cycle's stimulus
      strobe = (n_wr <= int'(tv.w_max)) && draw_percent(int'(tv.sv_pct));
      clken         <= draw_percent(int'(tv.ck_pct));
      s_valid_ready <= strobe;
      s_data        <= strobe ? table_byte(tv.base, n_wr) : ~table_byte(tv.base, n_wr);
      m_ready       <= draw_percent(int'(tv.mr_pct));
    end
    assert (first_seen === tv.first_word) else begin
      $display("mismatch m_data first word: expected 0x%08h, got 0x%08h",
               tv.first_word, first_seen);
      errs++;
    end
    assert (last_seen === tv.last_word) else begin
      $display("mismatch m_data last word: expected 0x%08h, got 0x%08h",
               tv.last_word, last_seen);
      errs++;
    end
    $display("test %0d: %0d writes, %0d reads, %0d errors", t + 1, n_wr, n_rd, errs);
    total_errs += errs;
    if (errs != 0) failed_tests++;
  endtask

  // Stall guard armed once the table is known
  initial begin
    wait (budget_ns > 0);
    #(budget_ns);
    $display("Run stalled: no finish after %0d ns, the DUT stopped responding", budget_ns);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    longint budget;
    rst_req       <= 1'b0;
    clken         <= 1'b0;
    s_valid_ready <= 1'b0;
    s_data        <= '0;
    m_ready       <= 1'b0;
    w_addr_max_1  <= '1;
    r_addr_max_1  <= '1;
    load_tests();
    if (!load_ok) begin
      $display("Simulation finished: FAIL");
      $finish;
    end else begin
      budget = 2000;
      foreach (tests[i]) begin
        budget += longint'(20 * (int'(tests[i].w_max) + 1 + int'(tests[i].n_reads))
                           * CLK_NS + 40 * CLK_NS); // Reset cycles on top
      end
      budget_ns = budget; // Whole budget in one step
      @(posedge rst_n);
      foreach (tests[i]) begin
        run_test(i);
      end
      $display("Summary: %0d tests run, %0d failed, %0d errors",
               tests.size(), failed_tests, total_errs);
      if (total_errs == 0) begin
        $display("Simulation finished: PASS");
      end else begin
        $display("Simulation finished: FAIL");
      end
      $finish;
    end
  end

endmodule

// File: verilog.f
verilog/bram_geom_pkg.sv
verilog/cyc_buf_pkg.sv
verilog/n_delay.sv
verilog/sdp_bram.sv
verilog/always_valid_cyclic_bram.sv
verilog/lrelu_param_store.sv
verif/tb_clk_rst.sv
verif/tb_lrelu_param_store.sv

// File: Makefile
# Verilator build and run for the parameter store

VERILATOR ?= verilator
TOP       ?= tb_lrelu_param_store
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TESTDATA  ?= verif/cyclic_bram_testdata.txt
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0 -Wno-fatal

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Runs from the project root so the test table path resolves
run: $(BIN) $(TESTDATA)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
	  echo "Failure reported in $(LOG)"; \
	  exit 1; \
	fi
	@grep -q "Simulation finished: PASS" $(LOG) || \
	  (echo "No pass line found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/cyclic_bram_testdata.txt
# w_addr_max_1 r_addr_max_1 reads valid% ready% clken% base first_word last_word
# Counts and percentages in decimal, base byte and words in hex
63 15 16 100 100 100 00 09060300 bdbab7b4
63 15 40 100 100 100 11 1a171411 6e6b6865
63 15 48 100 50 100 40 49464340 fdfaf7f4
31 7 20 100 100 100 80 89868380 adaaa7a4
63 15 20 60 100 100 c5 cecbc8c5 f2efece9
63 15 36 80 80 60 2a 33302d2a 5754514e
31 7 30 70 60 70 f0 f9f6f3f0 35322f2c
